// ==== mic_meter_settings.svh ====
// Microphone level meter build settings for clock, SPI framing, peak window and display

`ifndef MIC_METER_SETTINGS_SVH
`define MIC_METER_SETTINGS_SVH

//----------------------------------------------------------
// Clock and PmodMIC3 SPI framing

`define MIC_CLK_MHZ      50    // System clock rate
`define MIC_SCK_HALF     4     // Clocks per sck half period
`define MIC_FRAME_BITS   16    // Bits per cs frame
`define MIC_CS_GAP       8     // Clocks of cs high between frames

//----------------------------------------------------------
// Level processing and display

`define MIC_PEAK_WINDOW  8     // Samples per peak window
`define MIC_LED_T0       256   // Bar graph thresholds
`define MIC_LED_T1       512
`define MIC_LED_T2       1024
`define MIC_LED_T3       1536
`define MIC_SCAN_DIV     16    // Clocks per lit digit

`endif

// ==== mic_meter_pkg.sv ====
// Shared types of the microphone level meter pipeline

package mic_meter_pkg;

    //----------------------------------------------------------
    // Datapath types

    // Distance of a sample from midscale, 0 to 2048
    typedef logic [11:0] magnitude_t;

    // Stage 1 to stage 2
    typedef struct packed {
        logic        valid;  // One-cycle pulse per frame
        logic [11:0] value;  // Offset binary, 2048 is silence
    } sample_t;

    // Stage 2 to stage 3
    typedef struct packed {
        logic       valid;   // One cycle after sample valid
        magnitude_t peak;    // Held peak of the current window
        magnitude_t mag;     // Magnitude of the latest sample
    } level_t;

    //----------------------------------------------------------
    // Control types

    typedef enum logic [1:0] {
        IDLE_GAP,            // cs high between frames
        SHIFT,               // cs low, sck running
        DONE                 // Frame captured, emit sample
    } spi_state_t;

endpackage

// ==== mic3_spi_receiver.sv ====
// PmodMIC3 SPI receiver that drives cs and sck and captures one 12-bit sample per frame

`timescale 1ns/1ps

`include "mic_meter_settings.svh"

module mic3_spi_receiver (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   mic_sdo,
    output logic                   mic_cs,
    output logic                   mic_sck,
    output mic_meter_pkg::sample_t sample
);

    localparam int HALF_W = $clog2(`MIC_SCK_HALF + 1);
    localparam int BIT_W  = $clog2(`MIC_FRAME_BITS + 1);
    localparam int GAP_W  = $clog2(`MIC_CS_GAP + 1);

    mic_meter_pkg::spi_state_t  state;
    logic [HALF_W-1:0]          half_cnt;
    logic [BIT_W-1:0]           bit_cnt;
    logic [GAP_W-1:0]           gap_cnt;
    logic [`MIC_FRAME_BITS-1:0] shift_reg;
    logic                       sample_valid;
    logic [11:0]                sample_value;

    wire half_end = (half_cnt == HALF_W'(`MIC_SCK_HALF - 1));
    wire last_bit = (bit_cnt == BIT_W'(`MIC_FRAME_BITS - 1));
    wire sck_rise = (state == mic_meter_pkg::SHIFT) && half_end && !mic_sck;

    //----------------------------------------------------------
    // Frame sequencing

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= mic_meter_pkg::IDLE_GAP;
            mic_cs       <= 1'b1;
            mic_sck      <= 1'b1;                     // sck idles high
            half_cnt     <= '0;
            bit_cnt      <= '0;
            gap_cnt      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            case (state)
                mic_meter_pkg::IDLE_GAP: begin
                    if (gap_cnt == GAP_W'(`MIC_CS_GAP - 1)) begin
                        gap_cnt  <= '0;
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                        mic_cs   <= 1'b0;             // Frame starts
                        state    <= mic_meter_pkg::SHIFT;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                mic_meter_pkg::SHIFT: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        mic_sck  <= ~mic_sck;
                        if (sck_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (last_bit)
                                state <= mic_meter_pkg::DONE;
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                mic_meter_pkg::DONE: begin
                    sample_valid <= 1'b1;             // One clock after last rise
                    mic_cs       <= 1'b1;
                    state        <= mic_meter_pkg::IDLE_GAP;
                end
                default: state <= mic_meter_pkg::IDLE_GAP;
            endcase
        end
    end

    //----------------------------------------------------------
    // Data capture, MSB first on each sck rise

    always_ff @(posedge clk) begin
        if (sck_rise)
            shift_reg <= {shift_reg[`MIC_FRAME_BITS-2:0], mic_sdo};
        if (state == mic_meter_pkg::DONE)
            sample_value <= shift_reg[11:0];          // Drop the four leading zeros
    end

    assign sample = '{valid: sample_valid, value: sample_value};

endmodule

// ==== peak_level_tracker.sv ====
// Peak tracker that turns each sample into a magnitude and holds its peak per window

`timescale 1ns/1ps

`include "mic_meter_settings.svh"

module peak_level_tracker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  mic_meter_pkg::sample_t sample,
    output mic_meter_pkg::level_t  level
);

    localparam int          WIN_W    = $clog2(`MIC_PEAK_WINDOW + 1);
    localparam logic [11:0] MIDSCALE = 12'd2048;

    mic_meter_pkg::magnitude_t mag;
    mic_meter_pkg::magnitude_t peak_next;
    logic [WIN_W-1:0]          win_cnt;
    logic                      win_first;

    //----------------------------------------------------------
    // Magnitude and peak selection

    always_comb begin
        if (sample.value >= MIDSCALE)
            mag = sample.value - MIDSCALE;
        else
            mag = MIDSCALE - sample.value;            // Up to 2048 for code 0
    end

    assign win_first = (win_cnt == '0);

    always_comb begin
        if (win_first || (mag > level.peak))
            peak_next = mag;                          // New window restarts the peak
        else
            peak_next = level.peak;
    end

    //----------------------------------------------------------
    // Window counter and output register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            win_cnt <= '0;
            level   <= '0;
        end else begin
            level.valid <= sample.valid;
            if (sample.valid) begin
                level.peak <= peak_next;
                level.mag  <= mag;
                if (win_cnt == WIN_W'(`MIC_PEAK_WINDOW - 1))
                    win_cnt <= '0;
                else
                    win_cnt <= win_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== level_display.sv ====
// Level display with a scanned four-digit hex readout of the peak and a LED bar graph

`timescale 1ns/1ps

`include "mic_meter_settings.svh"

module level_display (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mic_meter_pkg::level_t level,
    output logic [3:0]            led,
    output logic [7:0]            abcdefgh,
    output logic [3:0]            digit
);

    localparam int SCAN_W = $clog2(`MIC_SCAN_DIV + 1);

    mic_meter_pkg::magnitude_t peak_q;
    logic [SCAN_W-1:0]         scan_cnt;
    logic [1:0]                digit_idx;
    logic [15:0]               peak_hex;
    logic [3:0]                nibble;

    //----------------------------------------------------------
    // Peak latch and bar graph

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            peak_q <= '0;
            led    <= '0;
        end else if (level.valid) begin
            peak_q <= level.peak;
            led[0] <= (level.peak >= 12'(`MIC_LED_T0));
            led[1] <= (level.peak >= 12'(`MIC_LED_T1));
            led[2] <= (level.peak >= 12'(`MIC_LED_T2));
            led[3] <= (level.peak >= 12'(`MIC_LED_T3));
        end
    end

    //----------------------------------------------------------
    // Digit scan

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == SCAN_W'(`MIC_SCAN_DIV - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 1'b1;            // Next digit
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign peak_hex = {4'h0, peak_q};
    assign nibble   = peak_hex[digit_idx * 4 +: 4];   // Digit 0 is the low nibble
    assign digit    = 4'b0001 << digit_idx;

    // Segments a to g from the MSB, dot always off
    always_comb begin
        case (nibble)
            4'h0:    abcdefgh = 8'b1111_1100;
            4'h1:    abcdefgh = 8'b0110_0000;
            4'h2:    abcdefgh = 8'b1101_1010;
            4'h3:    abcdefgh = 8'b1111_0010;
            4'h4:    abcdefgh = 8'b0110_0110;
            4'h5:    abcdefgh = 8'b1011_0110;
            4'h6:    abcdefgh = 8'b1011_1110;
            4'h7:    abcdefgh = 8'b1110_0000;
            4'h8:    abcdefgh = 8'b1111_1110;
            4'h9:    abcdefgh = 8'b1111_0110;
            4'ha:    abcdefgh = 8'b1110_1110;
            4'hb:    abcdefgh = 8'b0011_1110;
            4'hc:    abcdefgh = 8'b1001_1100;
            4'hd:    abcdefgh = 8'b0111_1010;
            4'he:    abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;         // F
        endcase
    end

endmodule

// ==== mic_meter_top.sv ====
// Microphone level meter core chaining the SPI receiver, peak tracker and display

`timescale 1ns/1ps

module mic_meter_top (
    input  logic       clk,
    input  logic       arst_n,

    input  logic       mic_sdo,
    output logic       mic_cs,
    output logic       mic_sck,

    output logic [3:0] led,
    output logic [7:0] abcdefgh,
    output logic [3:0] digit
);

    mic_meter_pkg::sample_t sample;
    mic_meter_pkg::level_t  level;

    //----------------------------------------------------------
    // Three-stage pipeline

    mic3_spi_receiver i_mic3_spi_receiver (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .mic_sdo ( mic_sdo ),
        .mic_cs  ( mic_cs  ),
        .mic_sck ( mic_sck ),
        .sample  ( sample  )
    );

    peak_level_tracker i_peak_level_tracker (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .sample ( sample ),
        .level  ( level  )
    );

    level_display i_level_display (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .level    ( level    ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

// ==== board_specific_top.sv ====
// Board pin adapter for the level meter with active-low LED, segment and digit outputs

`timescale 1ns/1ps

module board_specific_top (
    input  logic       clk,
    input  logic       arst_n,

    input  logic       mic_sdo,     // PmodMIC3 data out
    output logic       mic_cs,
    output logic       mic_sck,

    output logic [3:0] led,         // Active low
    output logic [7:0] seg,         // Active low
    output logic [3:0] dig          // Active low
);

    logic [3:0] top_led;
    logic [7:0] abcdefgh;
    logic [3:0] digit;

    //----------------------------------------------------------

    mic_meter_top i_mic_meter_top (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .mic_sdo  ( mic_sdo  ),
        .mic_cs   ( mic_cs   ),
        .mic_sck  ( mic_sck  ),
        .led      ( top_led  ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    //----------------------------------------------------------
    // Board drives these pins low to light them

    assign led = ~top_led;
    assign seg = ~abcdefgh;
    assign dig = ~digit;

endmodule

// ==== tb_mic3_model.sv ====
// Behavioral PmodMIC3 model that answers each cs frame with a queued 12-bit sample

`timescale 1ns/1ps

module tb_mic3_model (
    input  logic        clk,
    input  logic        push_valid,
    input  logic [11:0] push_value,
    input  logic        mic_cs,
    input  logic        mic_sck,
    output logic        mic_sdo
);

    logic [11:0] values[$];                           // Samples waiting for a frame
    logic [15:0] word;
    int          bit_idx;

    always @(posedge clk) begin
        if (push_valid)
            values.push_back(push_value);
    end

    //------------------------------------------------------------
    // Frame response, four zeros then the sample, MSB first

    initial begin
        mic_sdo = 1'b0;
        #1;                                           // Skip edges from power-up
        forever begin
            @(negedge mic_cs);
            word = (values.size() > 0) ? {4'h0, values.pop_front()} : 16'h0800;
            for (bit_idx = 15; bit_idx >= 0; bit_idx--) begin
                @(negedge mic_sck);
                mic_sdo <= word[bit_idx];             // Stable until the next sck rise
            end
        end
    end

endmodule

// ==== tb_board_specific_top.sv ====
// Directed testbench for the level meter board top driven by a PmodMIC3 model

`timescale 1ns/1ps

`include "mic_meter_settings.svh"

module tb_board_specific_top;

    localparam int FRAME_CLKS    = 2 * `MIC_SCK_HALF * `MIC_FRAME_BITS + 1 + `MIC_CS_GAP;
    localparam int WIN           = `MIC_PEAK_WINDOW;
    localparam int TEST_FRAMES   = 14 * (WIN + 2) + 5;  // 14 window-aligned sends
    localparam int WATCHDOG_CLKS = (TEST_FRAMES + 10) * FRAME_CLKS;

    logic        clk;
    logic        arst_n;
    logic        mic_sdo;
    logic        mic_cs;
    logic        mic_sck;
    logic [3:0]  led;
    logic [7:0]  seg;
    logic [3:0]  dig;
    logic        push_valid;
    logic [11:0] push_value;
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          win_pos;                             // Samples so far in the window
    logic [11:0] exp_q[$];                            // Values the model still owes

    mic_meter_pkg::sample_t dut_sample;

    assign dut_sample = i_board_specific_top.i_mic_meter_top.sample;

    board_specific_top i_board_specific_top (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .mic_sdo ( mic_sdo ),
        .mic_cs  ( mic_cs  ),
        .mic_sck ( mic_sck ),
        .led     ( led     ),
        .seg     ( seg     ),
        .dig     ( dig     )
    );

    tb_mic3_model i_tb_mic3_model (
        .clk        ( clk        ),
        .push_valid ( push_valid ),
        .push_value ( push_value ),
        .mic_cs     ( mic_cs     ),
        .mic_sck    ( mic_sck    ),
        .mic_sdo    ( mic_sdo    )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //------------------------------------------------------------
    // Reference rules

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [3:0] bar_of(input int mag);
        return {mag >= `MIC_LED_T3, mag >= `MIC_LED_T2, mag >= `MIC_LED_T1, mag >= `MIC_LED_T0};
    endfunction

    // Segments a to g from the MSB and the dot in bit 0
    function automatic logic [7:0] hex_glyph(input logic [3:0] n);
        case (n)
            4'h0:    return 8'hfc;
            4'h1:    return 8'h60;
            4'h2:    return 8'hda;
            4'h3:    return 8'hf2;
            4'h4:    return 8'h66;
            4'h5:    return 8'hb6;
            4'h6:    return 8'hbe;
            4'h7:    return 8'he0;
            4'h8:    return 8'hfe;
            4'h9:    return 8'hf6;
            4'ha:    return 8'hee;
            4'hb:    return 8'h3e;
            4'hc:    return 8'h9c;
            4'hd:    return 8'h7a;
            4'he:    return 8'h9e;
            default: return 8'h8e;
        endcase
    endfunction

    //------------------------------------------------------------
    // Compare tasks

    task automatic check_sample(input mic_meter_pkg::sample_t actual,
                                input mic_meter_pkg::sample_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR sample got 0x%04h expected 0x%04h", actual, expected);
        end
    endtask

    task automatic check_mag(input string name, input mic_meter_pkg::magnitude_t actual,
                             input mic_meter_pkg::magnitude_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s got 0x%03h expected 0x%03h", name, actual, expected);
        end
    endtask

    task automatic check_led(input logic [3:0] actual, input logic [3:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR led got 0x%h expected 0x%h", actual, expected);
        end
    endtask

    //------------------------------------------------------------
    // Stimulus and observation helpers

    // Every sample is checked against the model queue or silence
    always @(negedge clk) begin
        logic [11:0] value;
        if (arst_n && dut_sample.valid) begin
            value = (exp_q.size() > 0) ? exp_q.pop_front() : 12'd2048;
            check_sample(dut_sample, '{valid: 1'b1, value: value});
            win_pos = (win_pos + 1) % WIN;
        end
    end

    task automatic wait_sample();
        int n;
        for (n = 0; n < 2 * FRAME_CLKS; n++) begin
            @(negedge clk);
            if (dut_sample.valid)
                return;
        end
        errors++;
        $display("No sample from the receiver within two frame periods");
    endtask

    // Call on a rising edge inside the cs gap
    task automatic send_value(input logic [11:0] value);
        push_valid <= 1'b1;
        push_value <= value;
        exp_q.push_back(value);
        @(posedge clk);
        push_valid <= 1'b0;
    endtask

    // Returns in the gap before the first sample of a window
    task automatic align_window();
        int n;
        for (n = 0; n <= WIN; n++) begin
            wait_sample();
            @(posedge clk);
            if (win_pos == 0)
                return;
        end
        errors++;
        $display("Start of a peak window was never reached");
    endtask

    task automatic read_display(output logic [15:0] value);
        logic [3:0] nib[4];
        logic [3:0] seen;
        logic       bad;
        int         idx;
        int         glyph;
        int         n;
        int         k;
        seen = '0;
        bad  = 1'b0;
        for (k = 0; k < 4; k++)
            nib[k] = '0;
        for (n = 0; n < 4 * `MIC_SCAN_DIV; n++) begin
            @(negedge clk);
            idx   = -1;
            glyph = -1;
            for (k = 0; k < 4; k++)
                if (~dig == (4'b0001 << k))
                    idx = k;
            for (k = 0; k < 16; k++)
                if (hex_glyph(4'(k)) == ~seg)
                    glyph = k;
            if (idx < 0 || glyph < 0) begin
                bad = 1'b1;
            end else begin
                nib[idx]  = 4'(glyph);
                seen[idx] = 1'b1;
            end
        end
        if (bad || seen != 4'hf) begin
            errors++;
            $display("Display scan showed a bad digit select or an unknown segment pattern");
        end
        value = {nib[3], nib[2], nib[1], nib[0]};
        check_mag("display digit 3", 12'(nib[3]), 12'd0);  // Peak is zero-extended
    endtask

    // Display settles two clocks after the sample valid
    task automatic show_peak(input mic_meter_pkg::magnitude_t expected);
        logic [15:0] shown;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_led(led, ~bar_of(int'(expected)));
        read_display(shown);
        check_mag("display peak", shown[11:0], expected);
    endtask

    //------------------------------------------------------------
    // Directed tests

    task automatic after_reset();
        logic [15:0] shown;
        @(negedge clk);
        check_led(led, 4'hf);
        checks++;
        if ({mic_cs, mic_sck} !== 2'b11) begin
            errors++;
            $display("ERR mic_cs,mic_sck got 0x%h expected 0x3", {mic_cs, mic_sck});
        end
        read_display(shown);
        check_mag("display peak", shown[11:0], 12'd0);
    endtask

    task automatic spi_framing();
        int   n;
        int   falls;
        logic prev_sck;
        wait_sample();
        @(posedge clk);
        send_value(12'h5a3);
        falls = 0;
        for (n = 0; n < FRAME_CLKS; n++) begin
            @(negedge clk);
            if (!mic_cs)
                break;
        end
        if (mic_cs) begin
            errors++;
            $display("mic_cs never fell to start a frame");
            return;
        end
        prev_sck = mic_sck;
        while (!mic_cs) begin
            @(negedge clk);
            if (prev_sck && !mic_sck && !mic_cs)
                falls++;
            prev_sck = mic_sck;
        end
        checks++;
        if (falls != `MIC_FRAME_BITS) begin
            errors++;
            $display("ERR mic_sck falls got 0x%0h expected 0x%0h", falls, `MIC_FRAME_BITS);
        end
    endtask

    task automatic magnitude_both_signs();
        logic [11:0] d;
        int          n;
        int          b;
        for (n = 0; n < 2; n++) begin
            d = '0;
            for (b = 0; b < 11; b++)
                d = {d[10:0], lfsr_bit()};            // 0 to 2047
            align_window();
            send_value(12'd2048 + d);
            wait_sample();
            show_peak(d);
            align_window();
            send_value(12'd2048 - d);
            wait_sample();
            show_peak(d);
        end
    endtask

    task automatic peak_hold_window();
        align_window();
        send_value(12'd3548);                         // Magnitude 1500
        send_value(12'd1748);                         // Magnitude 300
        send_value(12'd2748);                         // Magnitude 700
        repeat (3) wait_sample();
        show_peak(12'd1500);
        align_window();
        send_value(12'd1948);                         // Next window restarts at 100
        wait_sample();
        show_peak(12'd100);
    endtask

    task automatic led_thresholds();
        int thr[4];
        int n;
        int delta;
        thr = '{`MIC_LED_T0, `MIC_LED_T1, `MIC_LED_T2, `MIC_LED_T3};
        for (n = 0; n < 4; n++) begin
            for (delta = 1; delta >= 0; delta--) begin
                align_window();
                send_value(12'(2048 + thr[n] - delta));
                wait_sample();
                show_peak(12'(thr[n] - delta));
            end
        end
    endtask

    //------------------------------------------------------------
    // Main sequence and watchdog

    initial begin
        arst_n     = 1'b0;
        push_valid = 1'b0;
        push_value = '0;
        lfsr       = 16'd33786;
        errors     = 0;
        checks     = 0;
        win_pos    = 0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        after_reset();
        spi_framing();
        magnitude_both_signs();
        peak_hold_window();
        led_thresholds();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Watchdog expired after %0d clocks before the tests finished", WATCHDOG_CLKS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
mic_meter_pkg.sv
mic3_spi_receiver.sv
peak_level_tracker.sv
level_display.sv
mic_meter_top.sv
board_specific_top.sv
tb_mic3_model.sv
tb_board_specific_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the level meter testbench with Verilator
verilator --binary --timing --top-module tb_board_specific_top -f vlog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0
